/* sources.f */
+incdir+source
source/zynq_shell_pkg.sv
source/host_csr_bank.sv
source/host_word_fifo.sv
source/config_rom.sv
source/dram_addr_remap.sv
source/zynq_shell_top.sv
bench/zynq_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module zynq_shell_tb -o sim_zynq_shell \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_zynq_shell 2>&1)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1

/* bench/zynq_shell_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module zynq_shell_tb;

  localparam int timeout_lp = 20;

  localparam logic [3:0] op_write     = 4'd0;
  localparam logic [3:0] op_read      = 4'd1;
  localparam logic [3:0] op_sys_reset = 4'd2;
  localparam logic [3:0] op_req_pop   = 4'd3;
  localparam logic [3:0] op_req_idle  = 4'd4;
  localparam logic [3:0] op_rsp_offer = 4'd5;
  localparam logic [3:0] op_dma       = 4'd6;

  // one row of the stimulus table
  typedef struct packed
  {
    logic [3:0]                   op;
    logic [`CSR_ADDR_WIDTH-1:0]   addr;
    logic [`SHELL_DATA_WIDTH-1:0] data;
    logic [`SHELL_DATA_WIDTH-1:0] expected;
  } step_s;

  logic                              aclk;
  logic                              rst;
  logic                              host_wr_v;
  zynq_shell_pkg::host_wr_s          host_wr;
  logic                              host_rd_v;
  logic [`CSR_ADDR_WIDTH-1:0]        host_rd_addr;
  wire  [`SHELL_DATA_WIDTH-1:0]      host_rd_data;
  wire                               host_rd_data_v;
  wire  [`SHELL_DATA_WIDTH-1:0]      req_data;
  wire                               req_v;
  logic                              req_yumi;
  logic [`SHELL_DATA_WIDTH-1:0]      rsp_data;
  logic                              rsp_v;
  wire                               rsp_ready;
  zynq_shell_pkg::cache_dma_addr_s   dma_aw;
  zynq_shell_pkg::cache_dma_addr_s   dma_ar;
  logic                              dma_aw_v;
  logic                              dma_ar_v;
  wire  [`SHELL_ADDR_WIDTH-1:0]      m_awaddr;
  wire                               m_awaddr_v;
  wire  [`SHELL_ADDR_WIDTH-1:0]      m_araddr;
  wire                               m_araddr_v;
  wire                               sys_reset;

  step_s                             steps[$];
  logic [`SHELL_ADDR_WIDTH-1:0]      model_base;
  int                                seed;

  zynq_shell_top i_zynq_shell_top
    (.aclk(aclk), .rst_i(rst)
     ,.host_wr_v_i(host_wr_v), .host_wr_i(host_wr)
     ,.host_rd_v_i(host_rd_v), .host_rd_addr_i(host_rd_addr)
     ,.host_rd_data_o(host_rd_data), .host_rd_data_v_o(host_rd_data_v)
     ,.req_data_o(req_data), .req_v_o(req_v), .req_yumi_i(req_yumi)
     ,.rsp_data_i(rsp_data), .rsp_v_i(rsp_v), .rsp_ready_o(rsp_ready)
     ,.dma_aw_i(dma_aw), .dma_aw_v_i(dma_aw_v)
     ,.dma_ar_i(dma_ar), .dma_ar_v_i(dma_ar_v)
     ,.m_awaddr_o(m_awaddr), .m_awaddr_v_o(m_awaddr_v)
     ,.m_araddr_o(m_araddr), .m_araddr_v_o(m_araddr_v)
     ,.sys_reset_o(sys_reset)
     );

  initial
  begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////
  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timed out after %0d cycles waiting for %s", timeout_lp, what);
    stop_run();
  endtask

  // words of the machine description
  function automatic logic [31:0] rom_word(input int idx);
    case (idx)
      0:       return 32'h0002_0001;
      1:       return 32'd4;
      2:       return 32'd4;
      3:       return 32'd16;
      4:       return 32'd27;
      5:       return 32'd4;
      default: return 32'd0;
    endcase
  endfunction

  // cache id above the offset plus the base modulo 2^32
  function automatic logic [31:0] expected_dram(input logic [3:0] id, input logic [31:0] addr);
    logic [31:0] offset_mask;
    offset_mask = (32'd1 << `CACHE_OFFSET_WIDTH) - 32'd1;
    return ({28'd0, id} << `CACHE_OFFSET_WIDTH) + (addr & offset_mask) + model_base;
  endfunction

  ////////////////////////////////////////
  // bus actions start on a falling edge
  ////////////////////////////////////////
  task automatic write_csr(input logic [2:0] addr, input logic [31:0] data);
    host_wr_v    = 1'b1;
    host_wr.addr = addr;
    host_wr.data = data;
    @(posedge aclk);
    @(negedge aclk);
    host_wr_v = 1'b0;
    if (addr == `CSR_DRAM_BASE)
      model_base = data;
  endtask

  task automatic read_csr(input logic [2:0] addr, input logic [31:0] exp);
    int cycles;
    host_rd_v    = 1'b1;
    host_rd_addr = addr;
    @(posedge aclk);
    @(negedge aclk);
    host_rd_v = 1'b0;
    cycles    = 0;
    while (!host_rd_data_v && cycles < timeout_lp)
    begin
      @(negedge aclk);
      cycles++;
    end
    if (!host_rd_data_v)
      timeout_fail("host_rd_data_v_o");
    check_value("host_rd_data_v_o delay", cycles, 32'd0);
    check_value("host_rd_data_o", host_rd_data, exp);
  endtask

  task automatic check_sys_reset(input logic [31:0] data, input logic exp_level);
    int cycles;
    write_csr(`CSR_RESET_N, data);
    cycles = 0;
    while (sys_reset !== exp_level && cycles < timeout_lp)
    begin
      @(negedge aclk);
      cycles++;
    end
    if (sys_reset !== exp_level)
      timeout_fail("sys_reset_o");
    check_value("sys_reset_o delay", cycles, `RESET_DEPTH);
  endtask

  task automatic pop_request(input logic [31:0] exp);
    int cycles;
    cycles = 0;
    while (!req_v && cycles < timeout_lp)
    begin
      @(negedge aclk);
      cycles++;
    end
    if (!req_v)
      timeout_fail("req_v_o");
    check_value("req_data_o", req_data, exp);
    req_yumi = 1'b1;
    @(posedge aclk);
    @(negedge aclk);
    req_yumi = 1'b0;
  endtask

  task automatic offer_response(input logic [31:0] data, input logic exp_ready);
    rsp_v    = 1'b1;
    rsp_data = data;
    check_value("rsp_ready_o", {31'b0, rsp_ready}, {31'b0, exp_ready});
    @(posedge aclk);
    @(negedge aclk);
    rsp_v = 1'b0;
  endtask

  // new random addresses on both channels every cycle
  task automatic run_dma_burst(input int beats);
    logic [31:0] exp_aw;
    logic [31:0] exp_ar;
    logic [31:0] r;
    for (int i = 0; i <= beats; i++)
    begin
      if (i > 0)
      begin
        check_value("m_awaddr_v_o", {31'b0, m_awaddr_v}, 32'd1);
        check_value("m_awaddr_o", m_awaddr, exp_aw);
        check_value("m_araddr_v_o", {31'b0, m_araddr_v}, 32'd1);
        check_value("m_araddr_o", m_araddr, exp_ar);
      end
      if (i < beats)
      begin
        r                 = $random(seed);
        dma_aw.cache_id   = r[3:0];
        dma_ar.cache_id   = r[7:4];
        dma_aw.cache_addr = $random(seed);
        dma_ar.cache_addr = $random(seed);
        exp_aw            = expected_dram(dma_aw.cache_id, dma_aw.cache_addr);
        exp_ar            = expected_dram(dma_ar.cache_id, dma_ar.cache_addr);
        dma_aw_v          = 1'b1;
        dma_ar_v          = 1'b1;
      end
      else
      begin
        dma_aw_v = 1'b0;
        dma_ar_v = 1'b0;
      end
      @(posedge aclk);
      @(negedge aclk);
    end
    check_value("m_awaddr_v_o", {31'b0, m_awaddr_v}, 32'd0);
    check_value("m_araddr_v_o", {31'b0, m_araddr_v}, 32'd0);
  endtask

  task automatic add_step(input logic [3:0] op, input logic [2:0] addr,
                          input logic [31:0] data, input logic [31:0] expected);
    steps.push_back('{op: op, addr: addr, data: data, expected: expected});
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  task automatic build_table();
    add_step(op_sys_reset, `CSR_RESET_N, 32'd1, 32'd0);
    add_step(op_read, `CSR_RESET_N, '0, 32'd1);
    add_step(op_sys_reset, `CSR_RESET_N, 32'd0, 32'd1);
    add_step(op_write, `CSR_DRAM_BASE, 32'h1234_5678, '0);
    add_step(op_read, `CSR_DRAM_BASE, '0, 32'h1234_5678);
    add_step(op_write, `CSR_ROM_ADDR, 32'd5, '0);
    add_step(op_read, `CSR_ROM_ADDR, '0, 32'd5);
    add_step(op_read, 3'd7, '0, '0);
    for (int i = 0; i < `ROM_ELS; i++)
    begin
      add_step(op_write, `CSR_ROM_ADDR, i, '0);
      add_step(op_read, `CSR_ROM_DATA, '0, rom_word(i));
    end
    // one word past full is dropped
    for (int i = 0; i <= `FIFO_DEPTH; i++)
      add_step(op_write, `CSR_REQ_PUSH, 32'ha000_0000 + i, '0);
    add_step(op_read, `CSR_STATUS, '0, 32'd3);
    for (int i = 0; i < `FIFO_DEPTH; i++)
      add_step(op_req_pop, '0, '0, 32'ha000_0000 + i);
    add_step(op_req_idle, '0, '0, 32'd0);
    add_step(op_read, `CSR_STATUS, '0, 32'd2);
    for (int i = 0; i <= `FIFO_DEPTH; i++)
      add_step(op_rsp_offer, '0, 32'hb000_0000 + i, (i < `FIFO_DEPTH) ? 32'd1 : 32'd0);
    add_step(op_read, `CSR_STATUS, '0, 32'd0);
    for (int i = 0; i < `FIFO_DEPTH; i++)
      add_step(op_read, `CSR_RSP_POP, '0, 32'hb000_0000 + i);
    add_step(op_read, `CSR_RSP_POP, '0, '0);
    add_step(op_read, `CSR_STATUS, '0, 32'd2);
    // base near the top so the sum wraps
    add_step(op_write, `CSR_DRAM_BASE, 32'hfc00_0000, '0);
    add_step(op_dma, '0, 32'd24, '0);
  endtask

  initial
  begin
    seed         = 32'h3ee0;
    rst          = 1'b1;
    host_wr_v    = 1'b0;
    host_wr      = '0;
    host_rd_v    = 1'b0;
    host_rd_addr = '0;
    req_yumi     = 1'b0;
    rsp_data     = '0;
    rsp_v        = 1'b0;
    dma_aw       = '0;
    dma_aw_v     = 1'b0;
    dma_ar       = '0;
    dma_ar_v     = 1'b0;
    model_base   = '0;
    build_table();
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;

    check_value("sys_reset_o", {31'b0, sys_reset}, 32'd1);
    check_value("req_v_o", {31'b0, req_v}, 32'd0);
    check_value("rsp_ready_o", {31'b0, rsp_ready}, 32'd1);
    check_value("host_rd_data_v_o", {31'b0, host_rd_data_v}, 32'd0);
    check_value("m_awaddr_v_o", {31'b0, m_awaddr_v}, 32'd0);
    check_value("m_araddr_v_o", {31'b0, m_araddr_v}, 32'd0);

    foreach (steps[i])
    begin
      case (steps[i].op)
        op_write:     write_csr(steps[i].addr, steps[i].data);
        op_read:      read_csr(steps[i].addr, steps[i].expected);
        op_sys_reset: check_sys_reset(steps[i].data, steps[i].expected[0]);
        op_req_pop:   pop_request(steps[i].expected);
        op_req_idle:  check_value("req_v_o", {31'b0, req_v}, steps[i].expected);
        op_rsp_offer: offer_response(steps[i].data, steps[i].expected[0]);
        op_dma:       run_dma_burst(steps[i].data);
        default:
        begin
          $display("step %0d has an unknown kind %0d", i, steps[i].op);
          stop_run();
        end
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/zynq_shell_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module zynq_shell_top
  (  input  wire                                aclk
   , input  wire                                rst_i

   // host side
   , input  wire                                host_wr_v_i
   , input  zynq_shell_pkg::host_wr_s           host_wr_i
   , input  wire                                host_rd_v_i
   , input  wire [`CSR_ADDR_WIDTH-1:0]          host_rd_addr_i
   , output wire [`SHELL_DATA_WIDTH-1:0]        host_rd_data_o
   , output wire                                host_rd_data_v_o

   // pl side queues
   , output wire [`SHELL_DATA_WIDTH-1:0]        req_data_o
   , output wire                                req_v_o
   , input  wire                                req_yumi_i
   , input  wire [`SHELL_DATA_WIDTH-1:0]        rsp_data_i
   , input  wire                                rsp_v_i
   , output wire                                rsp_ready_o

   // cache dma and dram
   , input  zynq_shell_pkg::cache_dma_addr_s    dma_aw_i
   , input  wire                                dma_aw_v_i
   , input  zynq_shell_pkg::cache_dma_addr_s    dma_ar_i
   , input  wire                                dma_ar_v_i
   , output wire [`SHELL_ADDR_WIDTH-1:0]        m_awaddr_o
   , output wire                                m_awaddr_v_o
   , output wire [`SHELL_ADDR_WIDTH-1:0]        m_araddr_o
   , output wire                                m_araddr_v_o

   , output wire                                sys_reset_o
   );

  wire [`SHELL_DATA_WIDTH-1:0] rom_data;
  wire [`ROM_ADDR_WIDTH-1:0]   rom_addr;
  wire [`SHELL_ADDR_WIDTH-1:0] dram_base;
  wire                         req_push;
  wire [`SHELL_DATA_WIDTH-1:0] req_push_data;
  wire                         req_full;
  wire                         req_empty;
  wire                         rsp_pop;
  wire [`SHELL_DATA_WIDTH-1:0] rsp_head;
  wire                         rsp_full;
  wire                         rsp_empty;

  host_csr_bank i_csr_bank
    (.aclk(aclk), .rst_i(rst_i)
     ,.host_wr_v_i(host_wr_v_i), .host_wr_i(host_wr_i)
     ,.host_rd_v_i(host_rd_v_i), .host_rd_addr_i(host_rd_addr_i)
     ,.host_rd_data_o(host_rd_data_o), .host_rd_data_v_o(host_rd_data_v_o)
     ,.rom_data_i(rom_data), .req_full_i(req_full)
     ,.rsp_data_i(rsp_head), .rsp_empty_i(rsp_empty)
     ,.req_push_o(req_push), .req_push_data_o(req_push_data)
     ,.rsp_pop_o(rsp_pop), .dram_base_o(dram_base)
     ,.rom_addr_o(rom_addr), .sys_reset_o(sys_reset_o)
     );

  ////////////////////////////////////////
  // host to pl requests
  ////////////////////////////////////////
  host_word_fifo #(.depth_p(`FIFO_DEPTH)) i_req_fifo
    (.aclk(aclk), .rst_i(rst_i)
     ,.push_i(req_push), .push_data_i(req_push_data), .pop_i(req_yumi_i)
     ,.pop_data_o(req_data_o), .full_o(req_full), .empty_o(req_empty)
     );

  assign req_v_o = ~req_empty;

  // pl to host responses
  host_word_fifo #(.depth_p(`FIFO_DEPTH)) i_rsp_fifo
    (.aclk(aclk), .rst_i(rst_i)
     ,.push_i(rsp_v_i & ~rsp_full), .push_data_i(rsp_data_i), .pop_i(rsp_pop)
     ,.pop_data_o(rsp_head), .full_o(rsp_full), .empty_o(rsp_empty)
     );

  assign rsp_ready_o = ~rsp_full;

  config_rom i_config_rom
    (.addr_i(rom_addr), .data_o(rom_data));

  dram_addr_remap i_dram_remap
    (.aclk(aclk), .rst_i(rst_i), .dram_base_i(dram_base)
     ,.dma_aw_i(dma_aw_i), .dma_aw_v_i(dma_aw_v_i)
     ,.dma_ar_i(dma_ar_i), .dma_ar_v_i(dma_ar_v_i)
     ,.m_awaddr_o(m_awaddr_o), .m_awaddr_v_o(m_awaddr_v_o)
     ,.m_araddr_o(m_araddr_o), .m_araddr_v_o(m_araddr_v_o)
     );

endmodule

`default_nettype wire

/* source/dram_addr_remap.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module dram_addr_remap
  (  input  wire                                    aclk
   , input  wire                                    rst_i

   , input  wire [`SHELL_ADDR_WIDTH-1:0]            dram_base_i

   , input  zynq_shell_pkg::cache_dma_addr_s        dma_aw_i
   , input  wire                                    dma_aw_v_i
   , input  zynq_shell_pkg::cache_dma_addr_s        dma_ar_i
   , input  wire                                    dma_ar_v_i

   , output logic [`SHELL_ADDR_WIDTH-1:0]           m_awaddr_o
   , output logic                                   m_awaddr_v_o
   , output logic [`SHELL_ADDR_WIDTH-1:0]           m_araddr_o
   , output logic                                   m_araddr_v_o
   );

  // cache id above a dram sized offset, then rebased
  function automatic logic [`SHELL_ADDR_WIDTH-1:0] remap_addr
    (input zynq_shell_pkg::cache_dma_addr_s dma
     , input logic [`SHELL_ADDR_WIDTH-1:0]  base);
    zynq_shell_pkg::dram_addr_u hashed;
    hashed.fields.pad      = '0;
    hashed.fields.cache_id = dma.cache_id;
    hashed.fields.offset   = dma.cache_addr[`CACHE_OFFSET_WIDTH-1:0];
    return hashed.flat + base;
  endfunction

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      m_awaddr_v_o <= 1'b0;
      m_araddr_v_o <= 1'b0;
    end
    else
    begin
      m_awaddr_v_o <= dma_aw_v_i;
      m_araddr_v_o <= dma_ar_v_i;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (dma_aw_v_i)
      m_awaddr_o <= remap_addr(dma_aw_i, dram_base_i);
    if (dma_ar_v_i)
      m_araddr_o <= remap_addr(dma_ar_i, dram_base_i);
  end

endmodule

`default_nettype wire

/* source/config_rom.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module config_rom
  (  input  wire [`ROM_ADDR_WIDTH-1:0]    addr_i
   , output logic [`SHELL_DATA_WIDTH-1:0] data_o
   );

  // machine description for the host runtime
  always_comb
  begin
    case (addr_i)
      `ROM_ADDR_WIDTH'(0): data_o = `ROM_VERSION;
      `ROM_ADDR_WIDTH'(1): data_o = `ROM_TILES_X;
      `ROM_ADDR_WIDTH'(2): data_o = `ROM_TILES_Y;
      `ROM_ADDR_WIDTH'(3): data_o = `SHELL_DATA_WIDTH'(`NUM_CACHE);
      `ROM_ADDR_WIDTH'(4): data_o = `SHELL_DATA_WIDTH'(`DRAM_ADDR_WIDTH);
      `ROM_ADDR_WIDTH'(5): data_o = `SHELL_DATA_WIDTH'(`FIFO_DEPTH);
      // spare entries
      default:             data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/host_word_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module host_word_fifo
  #(parameter int depth_p = `FIFO_DEPTH)
  (  input  wire                           aclk
   , input  wire                           rst_i

   , input  wire                           push_i
   , input  wire [`SHELL_DATA_WIDTH-1:0]   push_data_i
   , input  wire                           pop_i

   , output logic [`SHELL_DATA_WIDTH-1:0]  pop_data_o
   , output logic                          full_o
   , output logic                          empty_o
   );

  localparam int ptr_width_lp   = $clog2(depth_p);
  localparam int count_width_lp = $clog2(depth_p+1);

  logic [`SHELL_DATA_WIDTH-1:0] mem_r [depth_p];
  logic [ptr_width_lp-1:0]      wr_ptr_r;
  logic [ptr_width_lp-1:0]      rd_ptr_r;
  logic [count_width_lp-1:0]    count_r;
  logic                         push_ok;
  logic                         pop_ok;

  assign full_o  = (count_r == count_width_lp'(depth_p));
  assign empty_o = (count_r == '0);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // pointers wrap on their own for power of two depths
  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_r <= wr_ptr_r + ptr_width_lp'(1);
      if (pop_ok)
        rd_ptr_r <= rd_ptr_r + ptr_width_lp'(1);
      if (push_ok & ~pop_ok)
        count_r <= count_r + count_width_lp'(1);
      else if (pop_ok & ~push_ok)
        count_r <= count_r - count_width_lp'(1);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push_ok)
      mem_r[wr_ptr_r] <= push_data_i;
  end

  assign pop_data_o = mem_r[rd_ptr_r];

endmodule

`default_nettype wire

/* source/host_csr_bank.sv */
`default_nettype none
`timescale 1ns/100ps

`include "zynq_shell_settings.svh"

module host_csr_bank
  (  input  wire                            aclk
   , input  wire                            rst_i

   , input  wire                            host_wr_v_i
   , input  zynq_shell_pkg::host_wr_s       host_wr_i
   , input  wire                            host_rd_v_i
   , input  wire [`CSR_ADDR_WIDTH-1:0]      host_rd_addr_i
   , output logic [`SHELL_DATA_WIDTH-1:0]   host_rd_data_o
   , output logic                           host_rd_data_v_o

   , input  wire [`SHELL_DATA_WIDTH-1:0]    rom_data_i
   , input  wire                            req_full_i
   , input  wire [`SHELL_DATA_WIDTH-1:0]    rsp_data_i
   , input  wire                            rsp_empty_i

   , output logic                           req_push_o
   , output logic [`SHELL_DATA_WIDTH-1:0]   req_push_data_o
   , output logic                           rsp_pop_o
   , output logic [`SHELL_ADDR_WIDTH-1:0]   dram_base_o
   , output logic [`ROM_ADDR_WIDTH-1:0]     rom_addr_o
   , output logic                           sys_reset_o
   );

  logic [`SHELL_DATA_WIDTH-1:0] reset_n_r;
  logic [`SHELL_ADDR_WIDTH-1:0] dram_base_r;
  logic [`ROM_ADDR_WIDTH-1:0]   rom_addr_r;
  logic [`SHELL_DATA_WIDTH-1:0] rd_data_n;
  logic [`RESET_DEPTH-1:0]      reset_chain_r;

  ////////////////////////////////////////
  // host writes
  ////////////////////////////////////////
  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      reset_n_r   <= '0;
      dram_base_r <= '0;
      rom_addr_r  <= '0;
    end
    else if (host_wr_v_i)
    begin
      case (host_wr_i.addr)
        `CSR_RESET_N:   reset_n_r   <= host_wr_i.data;
        `CSR_DRAM_BASE: dram_base_r <= host_wr_i.data;
        `CSR_ROM_ADDR:  rom_addr_r  <= host_wr_i.data[`ROM_ADDR_WIDTH-1:0];
        default:        ;
      endcase
    end
  end

  // word is dropped when the queue is full
  assign req_push_o      = host_wr_v_i & (host_wr_i.addr == `CSR_REQ_PUSH) & ~req_full_i;
  assign req_push_data_o = host_wr_i.data;

  ////////////////////////////////////////
  // host reads with one cycle latency
  ////////////////////////////////////////
  always_comb
  begin
    case (host_rd_addr_i)
      `CSR_RESET_N:   rd_data_n = reset_n_r;
      `CSR_DRAM_BASE: rd_data_n = dram_base_r;
      `CSR_ROM_ADDR:  rd_data_n = {{(`SHELL_DATA_WIDTH-`ROM_ADDR_WIDTH){1'b0}}, rom_addr_r};
      `CSR_ROM_DATA:  rd_data_n = rom_data_i;
      `CSR_RSP_POP:   rd_data_n = rsp_empty_i ? '0 : rsp_data_i;
      `CSR_STATUS:    rd_data_n = {{(`SHELL_DATA_WIDTH-2){1'b0}}, rsp_empty_i, req_full_i};
      default:        rd_data_n = '0;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
      host_rd_data_v_o <= 1'b0;
    else
      host_rd_data_v_o <= host_rd_v_i;
  end

  always_ff @(posedge aclk)
  begin
    if (host_rd_v_i)
      host_rd_data_o <= rd_data_n;
  end

  // head is captured above on the same edge
  assign rsp_pop_o = host_rd_v_i & (host_rd_addr_i == `CSR_RSP_POP) & ~rsp_empty_i;

  // system reset delay held asserted out of reset
  always_ff @(posedge aclk)
  begin
    if (rst_i)
      reset_chain_r <= '1;
    else
      reset_chain_r <= {reset_chain_r[`RESET_DEPTH-2:0], ~reset_n_r[0]};
  end

  assign sys_reset_o = reset_chain_r[`RESET_DEPTH-1];
  assign dram_base_o = dram_base_r;
  assign rom_addr_o  = rom_addr_r;

endmodule

`default_nettype wire

/* source/zynq_shell_pkg.sv */
`default_nettype none

`include "zynq_shell_settings.svh"

package zynq_shell_pkg;

  // one host register write
  typedef struct packed
  {
    logic [`CSR_ADDR_WIDTH-1:0]   addr;
    logic [`SHELL_DATA_WIDTH-1:0] data;
  } host_wr_s;

  // address as it leaves a cache dma port
  typedef struct packed
  {
    logic [`LG_NUM_CACHE-1:0]     cache_id;
    logic [`SHELL_ADDR_WIDTH-1:0] cache_addr;
  } cache_dma_addr_s;

  typedef struct packed
  {
    logic [`SHELL_ADDR_WIDTH-`DRAM_ADDR_WIDTH-1:0] pad;
    logic [`LG_NUM_CACHE-1:0]                      cache_id;
    logic [`CACHE_OFFSET_WIDTH-1:0]                offset;
  } dram_addr_fields_s;

  // built from fields, consumed as a flat word
  typedef union packed
  {
    logic [`SHELL_ADDR_WIDTH-1:0] flat;
    dram_addr_fields_s            fields;
  } dram_addr_u;

endpackage

`default_nettype wire

/* source/zynq_shell_settings.svh */
`ifndef ZYNQ_SHELL_SETTINGS_SVH
`define ZYNQ_SHELL_SETTINGS_SVH

// host word and dram address
`define SHELL_DATA_WIDTH 32
`define SHELL_ADDR_WIDTH 32
`define CSR_ADDR_WIDTH 3

`define FIFO_DEPTH 4
`define RESET_DEPTH 3

// cache dma space
`define NUM_CACHE 16
`define LG_NUM_CACHE 4
// 128 MiB of dram
`define DRAM_ADDR_WIDTH 27
`define CACHE_OFFSET_WIDTH (`DRAM_ADDR_WIDTH - `LG_NUM_CACHE)

`define ROM_ELS 8
`define ROM_ADDR_WIDTH 3

////////////////////////////////////////
// host register map
////////////////////////////////////////
`define CSR_RESET_N 3'd0
`define CSR_DRAM_BASE 3'd1
`define CSR_ROM_ADDR 3'd2
`define CSR_REQ_PUSH 3'd3
`define CSR_ROM_DATA 3'd4
`define CSR_RSP_POP 3'd5
`define CSR_STATUS 3'd6

// machine configuration words
`define ROM_VERSION 32'h0002_0001
`define ROM_TILES_X 32'd4
`define ROM_TILES_Y 32'd4

`endif
